// ==== verilog/gb_video_pkg.sv ====
`default_nettype none

package gb_video_pkg;

    ////////////////////
    // Raster timing
    ////////////////////

    // Horizontal, in pixel clocks
    localparam int h_front = 16;
    localparam int h_sync  = 96;
    localparam int h_back  = 48;
    localparam int h_act   = 640;
    localparam int h_blank = h_front + h_sync + h_back;  // First active clock
    localparam int h_total = h_blank + h_act;

    // Vertical, in lines
    localparam int v_front = 10;
    localparam int v_sync  = 2;
    localparam int v_back  = 33;
    localparam int v_act   = 480;
    localparam int v_blank = v_front + v_sync + v_back;  // First active line
    localparam int v_total = v_blank + v_act;

    // Console window in active coordinates, upper bounds exclusive
    localparam int win_x0 = 80;
    localparam int win_x1 = 560;
    localparam int win_y0 = 24;
    localparam int win_y1 = 456;

    // Console picture
    localparam int gb_width  = 160;
    localparam int gb_height = 144;
    localparam int gb_scale  = 3;
    localparam int fb_depth  = gb_width * gb_height;
    localparam int fb_addr_w = 15;

    ////////////////////
    // Register map
    ////////////////////
    localparam logic [15:0] reg_base    = 16'h8000;
    localparam logic [15:0] pal0_addr   = reg_base + 16'd0;
    localparam logic [15:0] pal1_addr   = reg_base + 16'd1;
    localparam logic [15:0] pal2_addr   = reg_base + 16'd2;
    localparam logic [15:0] pal3_addr   = reg_base + 16'd3;
    localparam logic [15:0] border_addr = reg_base + 16'd4;

    // Default shades, lightest first
    localparam logic [23:0] pal0_init   = 24'hFFFFFF;
    localparam logic [23:0] pal1_init   = 24'hAAAAAA;
    localparam logic [23:0] pal2_init   = 24'h555555;
    localparam logic [23:0] pal3_init   = 24'h000000;
    localparam logic [23:0] border_init = 24'h000000;

    localparam int pipe_latency = 2;  // Timing signals to video outputs

    typedef enum logic [1:0] {
        idle,
        ack,
        wait_release
    } wb_state_t;

endpackage

`default_nettype wire

// ==== verilog/dvi_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvi_timing (
    input  logic       clk,
    input  logic       reset,
    input  logic       frame_sync,
    output logic       h_sync_n,
    output logic       v_sync_n,
    output logic       active,
    output logic       in_window,
    output logic [7:0] gb_x,
    output logic [7:0] gb_y
);

    logic [9:0] h_count;
    logic [9:0] v_count;
    logic [1:0] h_div;      // Clocks within one console pixel
    logic [1:0] v_div;      // Lines within one console row
    logic [7:0] gb_x_cnt;
    logic [7:0] gb_y_cnt;
    logic       line_end;
    logic       win_h;
    logic       win_v;

    assign line_end = (h_count == 10'(gb_video_pkg::h_total - 1));

    ////////////////////
    // Raster counters
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (frame_sync) begin  // Lock to the emulated frame
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            if (v_count == 10'(gb_video_pkg::v_total - 1))
                v_count <= '0;
            else
                v_count <= v_count + 10'd1;
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    // Divide-by-three steppers, realigned just before each window edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_div    <= '0;
            gb_x_cnt <= '0;
            v_div    <= '0;
            gb_y_cnt <= '0;
        end else begin
            if (h_count == 10'(gb_video_pkg::h_blank + gb_video_pkg::win_x0 - 1)) begin
                h_div    <= '0;
                gb_x_cnt <= '0;
            end else if (h_div == 2'(gb_video_pkg::gb_scale - 1)) begin
                h_div    <= '0;
                gb_x_cnt <= gb_x_cnt + 8'd1;
            end else begin
                h_div <= h_div + 2'd1;
            end

            if (line_end) begin
                if (v_count == 10'(gb_video_pkg::v_blank + gb_video_pkg::win_y0 - 1)) begin
                    v_div    <= '0;
                    gb_y_cnt <= '0;
                end else if (v_div == 2'(gb_video_pkg::gb_scale - 1)) begin
                    v_div    <= '0;
                    gb_y_cnt <= gb_y_cnt + 8'd1;
                end else begin
                    v_div <= v_div + 2'd1;
                end
            end
        end
    end

    ////////////////////
    // Decoded regions
    ////////////////////
    assign h_sync_n = !((h_count >= gb_video_pkg::h_front) &&
                        (h_count < gb_video_pkg::h_front + gb_video_pkg::h_sync));
    assign v_sync_n = !((v_count >= gb_video_pkg::v_front) &&
                        (v_count < gb_video_pkg::v_front + gb_video_pkg::v_sync));
    assign active   = (h_count >= gb_video_pkg::h_blank) && (v_count >= gb_video_pkg::v_blank);

    assign win_h = (h_count >= gb_video_pkg::h_blank + gb_video_pkg::win_x0) &&
                   (h_count < gb_video_pkg::h_blank + gb_video_pkg::win_x1);
    assign win_v = (v_count >= gb_video_pkg::v_blank + gb_video_pkg::win_y0) &&
                   (v_count < gb_video_pkg::v_blank + gb_video_pkg::win_y1);
    assign in_window = win_h && win_v;

    assign gb_x = in_window ? gb_x_cnt : 8'd0;  // Zero outside the window
    assign gb_y = in_window ? gb_y_cnt : 8'd0;

endmodule

`default_nettype wire

// ==== verilog/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  logic                               clk,

    // Port A, bus side
    input  logic                               a_we,
    input  logic [gb_video_pkg::fb_addr_w-1:0] a_addr,
    input  logic [1:0]                         a_wdata,
    output logic [1:0]                         a_rdata,

    // Port B, scan side
    input  logic [gb_video_pkg::fb_addr_w-1:0] b_addr,
    output logic [1:0]                         b_rdata
);

    ////////////////////
    // Shade storage
    ////////////////////

    // One 2-bit shade per console pixel, row major
    logic [1:0] mem [0:gb_video_pkg::fb_depth-1];

    // Port A with write and read-before-write
    always_ff @(posedge clk) begin
        if (a_we)
            mem[a_addr] <= a_wdata;
        a_rdata <= mem[a_addr];  // Old data on a write
    end

    // Port B is read only
    always_ff @(posedge clk) begin
        b_rdata <= mem[b_addr];  // Valid one clock after the address
    end

    // Both ports are clocked by the pixel clock, so the RAM
    // needs no clock crossing. The scan side never writes,
    // so a collision only means the scan sees the old shade
    // for one frame.

endmodule

`default_nettype wire

// ==== verilog/wb_fb_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_fb_slave (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [15:0]                        wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack,
    output logic                               fb_we,
    output logic [gb_video_pkg::fb_addr_w-1:0] fb_addr,
    output logic [1:0]                         fb_wdata,
    input  logic [1:0]                         fb_rdata,
    output logic [23:0]                        pal0,
    output logic [23:0]                        pal1,
    output logic [23:0]                        pal2,
    output logic [23:0]                        pal3,
    output logic [23:0]                        border_rgb
);

    gb_video_pkg::wb_state_t state;
    logic        wr_en;     // Write accepted this clock
    logic        pix_sel;   // Address falls in the frame buffer
    logic [31:0] rd_data;

    assign pix_sel = (wb_adr < 16'(gb_video_pkg::fb_depth));
    assign wr_en   = (state == gb_video_pkg::idle) && wb_cyc && wb_stb && wb_we;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= gb_video_pkg::idle;
        end else begin
            case (state)
                gb_video_pkg::idle:
                    if (wb_cyc && wb_stb)
                        state <= gb_video_pkg::ack;
                gb_video_pkg::ack:
                    state <= gb_video_pkg::wait_release;  // Single ack pulse
                gb_video_pkg::wait_release:
                    if (!wb_stb)
                        state <= gb_video_pkg::idle;
                default:
                    state <= gb_video_pkg::idle;
            endcase
        end
    end

    assign wb_ack = (state == gb_video_pkg::ack);

    // Port A follows the bus directly, read data lands in the ack clock
    assign fb_we    = wr_en && pix_sel;
    assign fb_addr  = wb_adr[gb_video_pkg::fb_addr_w-1:0];
    assign fb_wdata = wb_dat_w[1:0];

    ////////////////////
    // Colour registers
    ////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pal0       <= gb_video_pkg::pal0_init;
            pal1       <= gb_video_pkg::pal1_init;
            pal2       <= gb_video_pkg::pal2_init;
            pal3       <= gb_video_pkg::pal3_init;
            border_rgb <= gb_video_pkg::border_init;
        end else if (wr_en) begin
            case (wb_adr)
                gb_video_pkg::pal0_addr:   pal0       <= wb_dat_w[23:0];
                gb_video_pkg::pal1_addr:   pal1       <= wb_dat_w[23:0];
                gb_video_pkg::pal2_addr:   pal2       <= wb_dat_w[23:0];
                gb_video_pkg::pal3_addr:   pal3       <= wb_dat_w[23:0];
                gb_video_pkg::border_addr: border_rgb <= wb_dat_w[23:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;  // Unmapped reads as zero
        if (pix_sel) begin
            rd_data = {30'd0, fb_rdata};
        end else begin
            case (wb_adr)
                gb_video_pkg::pal0_addr:   rd_data = {8'd0, pal0};
                gb_video_pkg::pal1_addr:   rd_data = {8'd0, pal1};
                gb_video_pkg::pal2_addr:   rd_data = {8'd0, pal2};
                gb_video_pkg::pal3_addr:   rd_data = {8'd0, pal3};
                gb_video_pkg::border_addr: rd_data = {8'd0, border_rgb};
                default:                   rd_data = '0;
            endcase
        end
    end

    assign wb_dat_r = wb_ack ? rd_data : 32'd0;

endmodule

`default_nettype wire

// ==== verilog/pixel_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               h_sync_n,
    input  logic                               v_sync_n,
    input  logic                               active,
    input  logic                               in_window,
    input  logic [7:0]                         gb_x,
    input  logic [7:0]                         gb_y,
    output logic [gb_video_pkg::fb_addr_w-1:0] scan_addr,
    input  logic [1:0]                         scan_shade,
    input  logic [23:0]                        pal0,
    input  logic [23:0]                        pal1,
    input  logic [23:0]                        pal2,
    input  logic [23:0]                        pal3,
    input  logic [23:0]                        border_rgb,
    output logic                               hs,
    output logic                               vs,
    output logic                               de,
    output logic [23:0]                        rgb
);

    logic [gb_video_pkg::fb_addr_w-1:0] y_x128;
    logic [gb_video_pkg::fb_addr_w-1:0] y_x32;
    logic        hs_d1;
    logic        vs_d1;
    logic        act_d1;
    logic        win_d1;
    logic [23:0] shade_rgb;
    logic [23:0] pix_rgb;

    ////////////////////
    // Stage 1
    ////////////////////

    // gb_y * 160 as 128 + 32, the RAM registers this address
    assign y_x128    = {gb_y, 7'd0};
    assign y_x32     = {2'd0, gb_y, 5'd0};
    assign scan_addr = y_x128 + y_x32 + {7'd0, gb_x};

    // Flags travel alongside the RAM read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_d1  <= 1'b1;
            vs_d1  <= 1'b1;
            act_d1 <= 1'b0;
            win_d1 <= 1'b0;
        end else begin
            hs_d1  <= h_sync_n;
            vs_d1  <= v_sync_n;
            act_d1 <= active;
            win_d1 <= in_window;
        end
    end

    ////////////////////
    // Stage 2
    ////////////////////
    always_comb begin
        case (scan_shade)
            2'd0:    shade_rgb = pal0;
            2'd1:    shade_rgb = pal1;
            2'd2:    shade_rgb = pal2;
            default: shade_rgb = pal3;
        endcase
    end

    assign pix_rgb = win_d1 ? shade_rgb : border_rgb;  // Border fills the rest

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs  <= 1'b1;
            vs  <= 1'b1;
            de  <= 1'b0;
            rgb <= '0;
        end else begin
            hs  <= hs_d1;
            vs  <= vs_d1;
            de  <= act_d1;
            rgb <= act_d1 ? pix_rgb : 24'd0;  // Black in blanking
        end
    end

endmodule

`default_nettype wire

// ==== verilog/gb_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_display_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_sync,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [15:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        hs,
    output logic        vs,
    output logic        de,
    output logic [23:0] rgb
);

    // Raster to pipe
    logic       h_sync_n;
    logic       v_sync_n;
    logic       active;
    logic       in_window;
    logic [7:0] gb_x;
    logic [7:0] gb_y;

    // Frame buffer ports
    logic                               fb_we;
    logic [gb_video_pkg::fb_addr_w-1:0] fb_addr;
    logic [1:0]                         fb_wdata;
    logic [1:0]                         fb_rdata;
    logic [gb_video_pkg::fb_addr_w-1:0] scan_addr;
    logic [1:0]                         scan_shade;

    // Colour registers
    logic [23:0] pal0;
    logic [23:0] pal1;
    logic [23:0] pal2;
    logic [23:0] pal3;
    logic [23:0] border_rgb;

    dvi_timing u_timing (
        .clk        (clk),
        .reset      (reset),
        .frame_sync (frame_sync),
        .h_sync_n   (h_sync_n),
        .v_sync_n   (v_sync_n),
        .active     (active),
        .in_window  (in_window),
        .gb_x       (gb_x),
        .gb_y       (gb_y)
    );

    wb_fb_slave u_bus (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .fb_we      (fb_we),
        .fb_addr    (fb_addr),
        .fb_wdata   (fb_wdata),
        .fb_rdata   (fb_rdata),
        .pal0       (pal0),
        .pal1       (pal1),
        .pal2       (pal2),
        .pal3       (pal3),
        .border_rgb (border_rgb)
    );

    frame_buffer u_fb (
        .clk     (clk),
        .a_we    (fb_we),
        .a_addr  (fb_addr),
        .a_wdata (fb_wdata),
        .a_rdata (fb_rdata),
        .b_addr  (scan_addr),
        .b_rdata (scan_shade)
    );

    pixel_pipe u_pipe (
        .clk        (clk),
        .reset      (reset),
        .h_sync_n   (h_sync_n),
        .v_sync_n   (v_sync_n),
        .active     (active),
        .in_window  (in_window),
        .gb_x       (gb_x),
        .gb_y       (gb_y),
        .scan_addr  (scan_addr),
        .scan_shade (scan_shade),
        .pal0       (pal0),
        .pal1       (pal1),
        .pal2       (pal2),
        .pal3       (pal3),
        .border_rgb (border_rgb),
        .hs         (hs),
        .vs         (vs),
        .de         (de),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_gb_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gb_display;

    typedef enum int {
        hs_fall,
        vs_fall,
        de_rise
    } edge_t;

    logic        clk;
    logic        reset;
    logic        frame_sync;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [15:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        hs;
    logic        vs;
    logic        de;
    logic [23:0] rgb;

    logic        prev_hs;   // Outputs at the previous sample
    logic        prev_vs;
    logic        prev_de;
    int          errors;
    int          checks;

    gb_display_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .frame_sync (frame_sync),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .hs         (hs),
        .vs         (vs),
        .de         (de),
        .rgb        (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Sampling helpers
    ////////////////////

    // Outputs are read 1 ns after the edge and inputs change at 2 ns
    task automatic sample_outputs();
        prev_hs = hs;
        prev_vs = vs;
        prev_de = de;
        @(posedge clk);
        #1;
    endtask

    function automatic bit edge_seen(input edge_t kind);
        case (kind)
            hs_fall: edge_seen = prev_hs && !hs;
            vs_fall: edge_seen = prev_vs && !vs;
            default: edge_seen = !prev_de && de;
        endcase
    endfunction

    task automatic wait_edge(input edge_t kind, input int limit, output bit found);
        int n;
        n = 0;
        found = 1'b0;
        while (!found && n < limit) begin
            sample_outputs();
            n++;
            found = edge_seen(kind);
        end
        if (!found) begin
            errors++;
            $display("Timeout: no %s edge seen within %0d clocks", kind.name(), limit);
        end
    endtask

    // One-clock restart pulse followed by a pixel pipe flush
    task automatic pulse_frame_sync();
        @(posedge clk);
        #2;
        frame_sync = 1'b1;
        @(posedge clk);
        #2;
        frame_sync = 1'b0;
        repeat (gb_video_pkg::pipe_latency)
            sample_outputs();
    endtask

    ////////////////////
    // Bus master
    ////////////////////
    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        bit got_ack;
        waited  = 0;
        got_ack = 1'b0;
        rdata   = '0;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        while (!got_ack && waited < 16) begin
            @(posedge clk);
            #1;
            waited++;
            if (wb_ack) begin
                got_ack = 1'b1;
                rdata   = wb_dat_r;  // Read data is valid with ack
            end
        end
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got_ack) begin
            errors++;
            $display("Timeout: no ack within 16 clocks for address %h", adr);
        end else begin
            checks++;
            assert (waited == 1) else begin
                errors++;
                $display("[ERROR] %0t: ack for %h after %0d clocks, expected 1",
                         $time, adr, waited);
            end
            @(posedge clk);
            #1;
            checks++;
            assert (!wb_ack) else begin
                errors++;
                $display("[ERROR] %0t: ack for %h held longer than one clock", $time, adr);
            end
        end
    endtask

    ////////////////////
    // Raster checks
    ////////////////////
    task automatic measure_raster();
        bit found;
        int n;
        int clocks;
        int low;
        int lines;
        int low_lines;
        int de_len;

        // Line period and hsync width
        wait_edge(hs_fall, 1600, found);
        clocks = 0;
        low    = 1;
        found  = 1'b0;
        while (!found && clocks < 1600) begin
            sample_outputs();
            clocks++;
            found = edge_seen(hs_fall);
            if (!found && !hs)
                low++;
        end
        checks += 2;
        assert (clocks == 800) else begin
            errors++;
            $display("[ERROR] %0t: hs period %0d clocks, expected 800", $time, clocks);
        end
        assert (low == 96) else begin
            errors++;
            $display("[ERROR] %0t: hs low for %0d clocks, expected 96", $time, low);
        end

        // Frame period in lines and vsync width
        wait_edge(vs_fall, 2 * 800 * 525, found);
        n         = 0;
        lines     = 0;
        low_lines = 0;
        found     = 1'b0;
        while (!found && n < 2 * 800 * 525) begin
            sample_outputs();
            n++;
            if (edge_seen(hs_fall)) begin
                lines++;
                if (!vs)
                    low_lines++;
            end
            found = edge_seen(vs_fall);
        end
        checks += 2;
        assert (lines == 525) else begin
            errors++;
            $display("[ERROR] %0t: vs period %0d lines, expected 525", $time, lines);
        end
        assert (low_lines == 2) else begin
            errors++;
            $display("[ERROR] %0t: vs low for %0d lines, expected 2", $time, low_lines);
        end

        // Active run within one line
        wait_edge(de_rise, 2 * 800 * 525, found);
        de_len = 1;
        while (de && de_len < 1000) begin
            sample_outputs();
            if (de)
                de_len++;
        end
        checks++;
        assert (de_len == 640) else begin
            errors++;
            $display("[ERROR] %0t: de high for %0d clocks, expected 640", $time, de_len);
        end
    endtask

    task automatic check_frame_restart();
        bit found;
        int n;
        int lines;
        wait_edge(vs_fall, 2 * 800 * 525, found);
        repeat (240)
            wait_edge(hs_fall, 1600, found);
        wait_edge(de_rise, 1600, found);  // Restart well inside an active line
        pulse_frame_sync();
        n     = 0;
        lines = 0;
        found = 1'b0;
        while (!found && n < 2 * 800 * 525) begin
            sample_outputs();
            n++;
            if (edge_seen(hs_fall))
                lines++;
            found = edge_seen(vs_fall);
        end
        if (!found) begin
            errors++;
            $display("Timeout: no vs falling edge after the frame restart");
        end else begin
            checks++;
            assert (lines == 10) else begin
                errors++;
                $display("[ERROR] %0t: vs fell %0d lines after restart, expected 10",
                         $time, lines);
            end
        end
    endtask

    // Counts de samples from a fresh frame up to active pixel (x, y)
    task automatic check_pixel(input int x, input int y, input logic [23:0] expected);
        int  target;
        int  idx;
        int  n;
        bit  done;
        target = y * 640 + x;
        idx    = 0;
        n      = 0;
        done   = 1'b0;
        pulse_frame_sync();
        while (!done && n < 2 * 800 * 525) begin
            sample_outputs();
            n++;
            if (de) begin
                if (idx == target) begin
                    done = 1'b1;
                    checks++;
                    assert (rgb == expected) else begin
                        errors++;
                        $display("[ERROR] %0t: pixel (%0d,%0d) is %h, expected %h",
                                 $time, x, y, rgb, expected);
                    end
                end
                idx++;
            end
        end
        if (!done) begin
            errors++;
            $display("Timeout: pixel (%0d,%0d) never reached within two frames", x, y);
        end
    endtask

    ////////////////////
    // Cases file
    ////////////////////
    task automatic run_cases();
        int            fd;
        int            code;
        bit            at_end;
        logic [63:0]   op_word;
        logic [1023:0] rest_line;
        logic [15:0]   adr;
        logic [31:0]   data;
        logic [31:0]   rdata;
        int            px;
        int            py;
        logic [23:0]   exp_rgb;

        at_end = 1'b0;
        fd = $fopen("testbench/gb_display_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/gb_display_cases.txt");
            at_end = 1'b1;
        end
        while (!at_end) begin
            code = $fscanf(fd, "%s", op_word);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (op_word == "#") begin
                code = $fgets(rest_line, fd);  // Comment line
            end else if (op_word == "W") begin
                code = $fscanf(fd, "%h %h", adr, data);
                bus_access(1'b1, adr, data, rdata);
            end else if (op_word == "R") begin
                code = $fscanf(fd, "%h %h", adr, data);
                bus_access(1'b0, adr, 32'd0, rdata);
                checks++;
                assert (rdata == data) else begin
                    errors++;
                    $display("[ERROR] %0t: read %h returned %h, expected %h",
                             $time, adr, rdata, data);
                end
            end else if (op_word == "P") begin
                code = $fscanf(fd, "%d %d %h", px, py, exp_rgb);
                check_pixel(px, py, exp_rgb);
            end else begin
                errors++;
                $display("Unknown operation in the cases file, line skipped");
                code = $fgets(rest_line, fd);
            end
        end
        if (fd != 0)
            $fclose(fd);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        frame_sync = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        prev_hs    = 1'b1;
        prev_vs    = 1'b1;
        prev_de    = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        checks++;
        assert (hs && vs && !de && !wb_ack) else begin
            errors++;
            $display("[ERROR] %0t: outputs in reset hs=%b vs=%b de=%b ack=%b",
                     $time, hs, vs, de, wb_ack);
        end
        #1;
        reset = 1'b0;

        measure_raster();
        check_frame_restart();
        run_cases();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/gb_display_cases.txt ====
# Columns: W addr data | R addr expected | P x y rgb
# addr, data, expected and rgb in hex; x and y are decimal active coordinates
R 8000 00FFFFFF
R 8001 00AAAAAA
R 8002 00555555
R 8003 00000000
R 8004 00000000
# Colour registers keep bits 23:0
W 8000 FF00FF00
R 8000 0000FF00
W 8001 AB0000FF
R 8001 000000FF
W 8002 00FF0000
R 8002 00FF0000
W 8003 00C0C0C0
R 8003 00C0C0C0
W 8004 00123456
R 8004 00123456
# Pixel shades at gb_y*160+gb_x
W 0000 00000001
R 0000 00000001
W 0001 FFFFFFFC
R 0001 00000000
W 032A 00000003
R 032A 00000003
W 59FF 0000000E
R 59FF 00000002
# Unmapped addresses
W 8010 12345678
R 8010 00000000
R 5A00 00000000
R FFFF 00000000
# Screen pixels
P 80 24 0000FF
P 82 26 0000FF
P 83 24 00FF00
P 111 40 C0C0C0
P 557 453 FF0000
P 559 455 FF0000
P 0 0 123456
P 79 24 123456
P 80 23 123456
P 560 455 123456
P 639 479 123456
# Palette change without a pixel rewrite
W 8001 00ABCDEF
P 81 25 ABCDEF

// ==== src.f ====
verilog/gb_video_pkg.sv
verilog/dvi_timing.sv
verilog/frame_buffer.sv
verilog/wb_fb_slave.sv
verilog/pixel_pipe.sv
verilog/gb_display_top.sv
testbench/tb_gb_display.sv

// ==== Bender.yml ====
package:
  name: gb_display

sources:
  - verilog/gb_video_pkg.sv
  - verilog/dvi_timing.sv
  - verilog/frame_buffer.sv
  - verilog/wb_fb_slave.sv
  - verilog/pixel_pipe.sv
  - verilog/gb_display_top.sv
  - target: test
    files:
      - testbench/tb_gb_display.sv
